/* rtl/ucodePkg.sv */
package ucodePkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int addrWidth = 16;
	localparam int dataWidth = 8;
	localparam int upcWidth  = 7;

	//////////////////////////////
	// Micro-instruction fields
	//////////////////////////////

	// Sequencer action, one per micro-instruction
	typedef enum logic [2:0]
	{
		seqOp      = 3'd0,
		seqInc     = 3'd1,
		seqEof     = 3'd2,
		seqIncEof  = 3'd3,
		seqIncEofZ = 3'd4,
		seqJcb     = 3'd5,
		seqHalt    = 3'd6
	} seqCtl_e;

	// Datapath operation
	typedef enum logic [3:0]
	{
		uNop    = 4'd0,
		uSma    = 4'd1,
		uSrm    = 4'd2,
		uSmw    = 4'd3,
		uInc16  = 4'd4,
		uDec16  = 4'd5,
		uSx16r  = 4'd6,
		uAddX16 = 4'd7,
		uSubX16 = 4'd8,
		uSpc    = 4'd9,
		uBit    = 4'd10
	} uOp_e;

	// Register or temporary the operation works on
	typedef enum logic [3:0]
	{
		rA, rB, rC, rH, rL, rHL, rSP, rSPL, rSPH, rPC, rX8, rX16, rNull
	} operand_e;

	typedef struct packed
	{
		seqCtl_e  seq;
		uOp_e     op;
		operand_e operand;
	} uInstr_t;

	// One bus access as the datapath asks for it
	typedef struct packed
	{
		logic                 valid;
		logic                 write;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
	} busReq_t;

	// Supported opcodes, CB page entry last
	typedef enum logic [7:0]
	{
		opLdAn   = 8'h3E,
		opLdBn   = 8'h06,
		opLdCn   = 8'h0E,
		opLdLn   = 8'h2E,
		opLdHLnn = 8'h21,
		opLdSPnn = 8'h31,
		opLdHLmA = 8'h77,
		opLdHLiA = 8'h22,
		opIncC   = 8'h0C,
		opDecA   = 8'h3D,
		opDecB   = 8'h05,
		opCpN    = 8'hFE,
		opJrN    = 8'h18,
		opJrNzN  = 8'h20,
		opCallNn = 8'hCD,
		opRet    = 8'hC9,
		opPushBC = 8'hC5,
		opCb     = 8'hCB,
		halt     = 8'h76,
		cbBit7H  = 8'h7C
	} opcode_e;

	// Opcode fetch, which also dispatches the next flow
	function automatic logic isFetch(input uInstr_t u);
		return (u.op == uSma) && ((u.seq == seqIncEof) || (u.seq == seqJcb));
	endfunction

	// Any micro-instruction that waits on the bus
	function automatic logic isMemOp(input uInstr_t u);
		return (u.op == uSrm) || (u.op == uSmw) || isFetch(u);
	endfunction

endpackage

/* rtl/opcodeDecoder.sv */
`timescale 1ns/1ps

module opcodeDecoder
(
	input  logic [ucodePkg::dataWidth-1:0] opcode,
	input  logic                           cbPrefix,
	output logic [ucodePkg::upcWidth-1:0]  flowStart
);

	logic [ucodePkg::upcWidth-1:0] mainStart;
	logic [ucodePkg::upcWidth-1:0] cbStart;

	// Main page
	always_comb
	begin
		case (opcode)
			ucodePkg::opLdAn:   mainStart = 7'd1;
			ucodePkg::opLdBn:   mainStart = 7'd3;
			ucodePkg::opLdCn:   mainStart = 7'd5;
			ucodePkg::opLdLn:   mainStart = 7'd7;
			ucodePkg::opLdHLnn: mainStart = 7'd9;
			ucodePkg::opLdSPnn: mainStart = 7'd12;
			ucodePkg::opLdHLmA: mainStart = 7'd15;
			ucodePkg::opLdHLiA: mainStart = 7'd17;
			ucodePkg::opIncC:   mainStart = 7'd20;
			ucodePkg::opDecA:   mainStart = 7'd21;
			ucodePkg::opDecB:   mainStart = 7'd22;
			ucodePkg::opCpN:    mainStart = 7'd23;
			ucodePkg::opJrN:    mainStart = 7'd27;
			ucodePkg::opJrNzN:  mainStart = 7'd32;
			ucodePkg::opCallNn: mainStart = 7'd37;
			ucodePkg::opRet:    mainStart = 7'd48;
			ucodePkg::opPushBC: mainStart = 7'd53;
			ucodePkg::opCb:     mainStart = 7'd58;
			ucodePkg::halt:     mainStart = 7'd60;
			// Unknown opcodes just fetch the next byte
			default:            mainStart = 7'd0;
		endcase
	end

	// CB page, only BIT 7,H is there
	always_comb
	begin
		case (opcode)
			ucodePkg::cbBit7H: cbStart = 7'd59;
			default:           cbStart = 7'd0;
		endcase
	end

	assign flowStart = cbPrefix ? cbStart : mainStart;

endmodule

/* rtl/microcodeRom.sv */
`timescale 1ns/1ps

module microcodeRom
(
	input  logic [ucodePkg::upcWidth-1:0] upc,
	output ucodePkg::uInstr_t             uInstr
);

	// PC points past the opcode when a flow starts
	// Every flow ends back at word 0, the opcode fetch
	always_comb
	begin
		case (upc)
			// Fetch, also the one-byte default flow
			7'd0:  uInstr = '{ucodePkg::seqIncEof,  ucodePkg::uSma,    ucodePkg::rPC};
			// LD A,n
			7'd1:  uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd2:  uInstr = '{ucodePkg::seqIncEof,  ucodePkg::uSrm,    ucodePkg::rA};
			// LD B,n
			7'd3:  uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd4:  uInstr = '{ucodePkg::seqIncEof,  ucodePkg::uSrm,    ucodePkg::rB};
			// LD C,n
			7'd5:  uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd6:  uInstr = '{ucodePkg::seqIncEof,  ucodePkg::uSrm,    ucodePkg::rC};
			// LD L,n
			7'd7:  uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd8:  uInstr = '{ucodePkg::seqIncEof,  ucodePkg::uSrm,    ucodePkg::rL};
			// LD HL,nn little endian
			7'd9:  uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd10: uInstr = '{ucodePkg::seqInc,     ucodePkg::uSrm,    ucodePkg::rL};
			7'd11: uInstr = '{ucodePkg::seqIncEof,  ucodePkg::uSrm,    ucodePkg::rH};
			// LD SP,nn
			7'd12: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd13: uInstr = '{ucodePkg::seqInc,     ucodePkg::uSrm,    ucodePkg::rSPL};
			7'd14: uInstr = '{ucodePkg::seqIncEof,  ucodePkg::uSrm,    ucodePkg::rSPH};
			// LD (HL),A
			7'd15: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rHL};
			7'd16: uInstr = '{ucodePkg::seqEof,     ucodePkg::uSmw,    ucodePkg::rA};
			// LD (HL+),A
			7'd17: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rHL};
			7'd18: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSmw,    ucodePkg::rA};
			7'd19: uInstr = '{ucodePkg::seqEof,     ucodePkg::uInc16,  ucodePkg::rHL};
			// INC C, DEC A, DEC B
			7'd20: uInstr = '{ucodePkg::seqEof,     ucodePkg::uInc16,  ucodePkg::rC};
			7'd21: uInstr = '{ucodePkg::seqEof,     ucodePkg::uDec16,  ucodePkg::rA};
			7'd22: uInstr = '{ucodePkg::seqEof,     ucodePkg::uDec16,  ucodePkg::rB};
			// CP n, x16 = A - n only for Z
			7'd23: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSx16r,  ucodePkg::rA};
			7'd24: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd25: uInstr = '{ucodePkg::seqInc,     ucodePkg::uSrm,    ucodePkg::rX8};
			7'd26: uInstr = '{ucodePkg::seqEof,     ucodePkg::uSubX16, ucodePkg::rX8};
			// JR n
			7'd27: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd28: uInstr = '{ucodePkg::seqInc,     ucodePkg::uSrm,    ucodePkg::rX8};
			7'd29: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSx16r,  ucodePkg::rPC};
			7'd30: uInstr = '{ucodePkg::seqOp,      ucodePkg::uAddX16, ucodePkg::rX8};
			7'd31: uInstr = '{ucodePkg::seqEof,     ucodePkg::uSpc,    ucodePkg::rX16};
			// JR NZ,n leaves early on Z
			7'd32: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			7'd33: uInstr = '{ucodePkg::seqIncEofZ, ucodePkg::uSrm,    ucodePkg::rX8};
			7'd34: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSx16r,  ucodePkg::rPC};
			7'd35: uInstr = '{ucodePkg::seqOp,      ucodePkg::uAddX16, ucodePkg::rX8};
			7'd36: uInstr = '{ucodePkg::seqEof,     ucodePkg::uSpc,    ucodePkg::rX16};
			// CALL nn, return address held in x16
			7'd37: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSx16r,  ucodePkg::rPC};
			7'd38: uInstr = '{ucodePkg::seqOp,      ucodePkg::uInc16,  ucodePkg::rX16};
			7'd39: uInstr = '{ucodePkg::seqOp,      ucodePkg::uInc16,  ucodePkg::rX16};
			7'd40: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rPC};
			// Target shifts into PC low byte first
			7'd41: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSrm,    ucodePkg::rPC};
			7'd42: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSrm,    ucodePkg::rPC};
			7'd43: uInstr = '{ucodePkg::seqOp,      ucodePkg::uDec16,  ucodePkg::rSP};
			7'd44: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rSP};
			// High byte then low byte, going down
			7'd45: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSmw,    ucodePkg::rX16};
			7'd46: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSmw,    ucodePkg::rX16};
			7'd47: uInstr = '{ucodePkg::seqEof,     ucodePkg::uDec16,  ucodePkg::rSP};
			// RET
			7'd48: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rSP};
			7'd49: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSrm,    ucodePkg::rPC};
			7'd50: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSrm,    ucodePkg::rPC};
			7'd51: uInstr = '{ucodePkg::seqOp,      ucodePkg::uInc16,  ucodePkg::rSP};
			7'd52: uInstr = '{ucodePkg::seqEof,     ucodePkg::uInc16,  ucodePkg::rSP};
			// PUSH BC
			7'd53: uInstr = '{ucodePkg::seqOp,      ucodePkg::uDec16,  ucodePkg::rSP};
			7'd54: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSma,    ucodePkg::rSP};
			7'd55: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSmw,    ucodePkg::rB};
			7'd56: uInstr = '{ucodePkg::seqOp,      ucodePkg::uSmw,    ucodePkg::rC};
			7'd57: uInstr = '{ucodePkg::seqEof,     ucodePkg::uDec16,  ucodePkg::rSP};
			// CB prefix fetches its second byte
			7'd58: uInstr = '{ucodePkg::seqJcb,     ucodePkg::uSma,    ucodePkg::rPC};
			// BIT 7,H
			7'd59: uInstr = '{ucodePkg::seqEof,     ucodePkg::uBit,    ucodePkg::rH};
			// HALT
			7'd60: uInstr = '{ucodePkg::seqHalt,    ucodePkg::uNop,    ucodePkg::rNull};
			default:
				uInstr = '{ucodePkg::seqOp, ucodePkg::uNop, ucodePkg::rNull};
		endcase
	end

endmodule

/* rtl/microSequencer.sv */
`timescale 1ns/1ps

module microSequencer
(
	input  logic                          clock,
	input  logic                          reset,
	input  ucodePkg::uInstr_t             uInstr,
	input  logic [ucodePkg::upcWidth-1:0] flowStart,
	input  logic                          busDone,
	input  logic                          zFlag,
	output logic [ucodePkg::upcWidth-1:0] upc,
	output logic                          cbPrefix,
	output logic                          incPc,
	output logic                          halted
);

	logic                          advance;
	logic [ucodePkg::upcWidth-1:0] nextUpc;

	// Memory words hold until the bus ack comes back
	assign advance  = !halted && (!ucodePkg::isMemOp(uInstr) || busDone);
	// Decoder looks at the CB page for this dispatch only
	assign cbPrefix = (uInstr.seq == ucodePkg::seqJcb);

	always_comb
	begin
		case (uInstr.seq)
			ucodePkg::seqInc,
			ucodePkg::seqIncEof,
			ucodePkg::seqIncEofZ,
			ucodePkg::seqJcb: incPc = advance;
			default:          incPc = 1'b0;
		endcase
	end

	//////////////////////////////
	// Next micro-PC
	//////////////////////////////

	always_comb
	begin
		case (uInstr.seq)
			ucodePkg::seqEof:     nextUpc = '0;
			// Fetch dispatches, any other eof rejoins the fetch
			ucodePkg::seqIncEof:  nextUpc = ucodePkg::isFetch(uInstr) ? flowStart : '0;
			ucodePkg::seqIncEofZ: nextUpc = zFlag ? '0 : upc + 7'd1;
			ucodePkg::seqJcb:     nextUpc = flowStart;
			ucodePkg::seqHalt:    nextUpc = upc;
			default:              nextUpc = upc + 7'd1;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			upc    <= '0;
			halted <= 1'b0;
		end
		else
		begin
			if (advance)
				upc <= nextUpc;
			// Sticky until reset
			if (uInstr.seq == ucodePkg::seqHalt)
				halted <= 1'b1;
		end
	end

endmodule

/* rtl/coreDatapath.sv */
`timescale 1ns/1ps

module coreDatapath
(
	input  logic                           clock,
	input  logic                           reset,
	input  ucodePkg::uInstr_t              uInstr,
	input  logic                           incPc,
	input  logic                           busDone,
	input  logic [ucodePkg::dataWidth-1:0] readData,
	output ucodePkg::busReq_t              busReq,
	output logic [ucodePkg::dataWidth-1:0] opcode,
	output logic                           zFlag
);

	logic [7:0]         a, b, c, h, l, x8;
	logic [7:0]         opcodeReg;
	logic [15:0]        sp, pc, x16, mar;
	logic               fetch;
	logic               step;
	logic               is8;
	logic               wrEn;
	logic [15:0]        opVal;
	logic [15:0]        res;
	logic [7:0]         wrByte;
	ucodePkg::operand_e dst;

	assign fetch = ucodePkg::isFetch(uInstr);
	// Bus words complete on busDone, others in one clock
	assign step  = !ucodePkg::isMemOp(uInstr) || busDone;
	assign is8   = uInstr.operand inside {ucodePkg::rA, ucodePkg::rB, ucodePkg::rC,
		ucodePkg::rH, ucodePkg::rL};

	// Decoder sees the new opcode in the cycle the fetch ends
	assign opcode = (fetch && busDone) ? readData : opcodeReg;

	//////////////////////////////
	// Operand read and ALU
	//////////////////////////////

	always_comb
	begin
		case (uInstr.operand)
			ucodePkg::rA:   opVal = {8'h00, a};
			ucodePkg::rB:   opVal = {8'h00, b};
			ucodePkg::rC:   opVal = {8'h00, c};
			ucodePkg::rH:   opVal = {8'h00, h};
			ucodePkg::rL:   opVal = {8'h00, l};
			ucodePkg::rHL:  opVal = {h, l};
			ucodePkg::rSP:  opVal = sp;
			ucodePkg::rSPL: opVal = {8'h00, sp[7:0]};
			ucodePkg::rSPH: opVal = {8'h00, sp[15:8]};
			ucodePkg::rPC:  opVal = pc;
			ucodePkg::rX8:  opVal = {8'h00, x8};
			ucodePkg::rX16: opVal = x16;
			default:        opVal = '0;
		endcase
	end

	always_comb
	begin
		dst  = uInstr.operand;
		res  = opVal;
		wrEn = 1'b0;
		case (uInstr.op)
			ucodePkg::uSrm:
			begin
				wrEn = 1'b1;
				// 16-bit targets take bytes low first
				case (uInstr.operand)
					ucodePkg::rX16: res = {readData, x16[15:8]};
					ucodePkg::rPC:  res = {readData, pc[15:8]};
					ucodePkg::rSPL: res = {sp[15:8], readData};
					ucodePkg::rSPH: res = {readData, sp[7:0]};
					default:        res = {8'h00, readData};
				endcase
			end
			// x16 stores high byte first, then shifts up
			ucodePkg::uSmw:
			begin
				wrEn = (uInstr.operand == ucodePkg::rX16);
				res  = {x16[7:0], 8'h00};
			end
			ucodePkg::uInc16:
			begin
				wrEn = 1'b1;
				res  = opVal + 16'd1;
			end
			ucodePkg::uDec16:
			begin
				wrEn = 1'b1;
				res  = opVal - 16'd1;
			end
			ucodePkg::uSx16r:
			begin
				wrEn = 1'b1;
				dst  = ucodePkg::rX16;
			end
			// Relative jump offset
			ucodePkg::uAddX16:
			begin
				wrEn = 1'b1;
				dst  = ucodePkg::rX16;
				res  = x16 + {{8{opVal[7]}}, opVal[7:0]};
			end
			ucodePkg::uSubX16:
			begin
				wrEn = 1'b1;
				dst  = ucodePkg::rX16;
				res  = x16 - opVal;
			end
			ucodePkg::uSpc:
			begin
				wrEn = 1'b1;
				dst  = ucodePkg::rPC;
			end
			default: ;
		endcase
	end

	//////////////////////////////
	// Bus request
	//////////////////////////////

	assign wrByte       = (uInstr.operand == ucodePkg::rX16) ? x16[15:8] : opVal[7:0];
	assign busReq.valid = ucodePkg::isMemOp(uInstr);
	assign busReq.write = (uInstr.op == ucodePkg::uSmw);
	assign busReq.addr  = fetch ? pc : mar;
	assign busReq.wdata = wrByte;

	// PC, SP, Z and opcode
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc        <= '0;
			sp        <= 16'hFFFE;
			zFlag     <= 1'b0;
			opcodeReg <= '0;
		end
		else
		begin
			if (incPc)
				pc <= pc + 16'd1;
			if (step)
			begin
				if (wrEn && dst == ucodePkg::rPC)
					pc <= res;
				if (wrEn && dst inside {ucodePkg::rSP, ucodePkg::rSPL, ucodePkg::rSPH})
					sp <= res;
				if (fetch)
					opcodeReg <= readData;
				case (uInstr.op)
					ucodePkg::uInc16,
					ucodePkg::uDec16:  if (is8) zFlag <= (res[7:0] == 8'h00);
					ucodePkg::uSubX16: zFlag <= (res[7:0] == 8'h00);
					ucodePkg::uBit:    zFlag <= !opVal[7];
					default: ;
				endcase
			end
		end
	end

	// Register file, temporaries and address register
	always_ff @(posedge clock)
	begin
		if (step)
		begin
			if (wrEn)
			begin
				case (dst)
					ucodePkg::rA:   a <= res[7:0];
					ucodePkg::rB:   b <= res[7:0];
					ucodePkg::rC:   c <= res[7:0];
					ucodePkg::rH:   h <= res[7:0];
					ucodePkg::rL:   l <= res[7:0];
					ucodePkg::rHL:  {h, l} <= res;
					ucodePkg::rX8:  x8 <= res[7:0];
					ucodePkg::rX16: x16 <= res;
					default: ;
				endcase
			end
			// Reads stream up, writes stream down
			case (uInstr.op)
				ucodePkg::uSma: mar <= opVal;
				ucodePkg::uSrm: mar <= mar + 16'd1;
				ucodePkg::uSmw: mar <= mar - 16'd1;
				default: ;
			endcase
		end
	end

endmodule

/* rtl/wishboneMaster.sv */
`timescale 1ns/1ps

module wishboneMaster
(
	input  logic                           clock,
	input  logic                           reset,
	input  ucodePkg::busReq_t              busReq,
	output logic                           busDone,
	output logic [ucodePkg::dataWidth-1:0] readData,
	output logic                           cyc,
	output logic                           stb,
	output logic                           we,
	output logic [ucodePkg::addrWidth-1:0] adr,
	output logic [ucodePkg::dataWidth-1:0] datOut,
	input  logic [ucodePkg::dataWidth-1:0] datIn,
	input  logic                           ack
);

	typedef enum logic
	{
		busIdle,
		busActive
	} busState_e;

	busState_e state;
	logic      start;

	// Requester still shows the finished word during busDone
	assign start = (state == busIdle) && busReq.valid && !busDone;
	assign cyc   = (state == busActive);
	assign stb   = (state == busActive);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state   <= busIdle;
			busDone <= 1'b0;
			we      <= 1'b0;
		end
		else
		begin
			busDone <= 1'b0;
			if (start)
			begin
				state <= busActive;
				we    <= busReq.write;
			end
			else if (state == busActive && ack)
			begin
				state   <= busIdle;
				busDone <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Address and data
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		// Held stable for the whole cycle
		if (start)
		begin
			adr    <= busReq.addr;
			datOut <= busReq.wdata;
		end
		if (state == busActive && ack)
			readData <= datIn;
	end

endmodule

/* rtl/microCore.sv */
`timescale 1ns/1ps

module microCore
(
	input  logic                           clock,
	input  logic                           reset,
	output logic                           cyc,
	output logic                           stb,
	output logic                           we,
	output logic [ucodePkg::addrWidth-1:0] adr,
	output logic [ucodePkg::dataWidth-1:0] datOut,
	input  logic [ucodePkg::dataWidth-1:0] datIn,
	input  logic                           ack,
	output logic                           halted
);

	ucodePkg::uInstr_t              uInstr;
	ucodePkg::busReq_t              busReq;
	logic [ucodePkg::upcWidth-1:0]  upc;
	logic [ucodePkg::upcWidth-1:0]  flowStart;
	logic [ucodePkg::dataWidth-1:0] opcode;
	logic [ucodePkg::dataWidth-1:0] readData;
	logic                           cbPrefix;
	logic                           incPc;
	logic                           zFlag;
	logic                           busDone;

	// Opcode to flow start
	opcodeDecoder decoder
	(
		.opcode    (opcode),
		.cbPrefix  (cbPrefix),
		.flowStart (flowStart)
	);

	microcodeRom rom
	(
		.upc    (upc),
		.uInstr (uInstr)
	);

	microSequencer sequencer
	(
		.clock     (clock),
		.reset     (reset),
		.uInstr    (uInstr),
		.flowStart (flowStart),
		.busDone   (busDone),
		.zFlag     (zFlag),
		.upc       (upc),
		.cbPrefix  (cbPrefix),
		.incPc     (incPc),
		.halted    (halted)
	);

	coreDatapath datapath
	(
		.clock    (clock),
		.reset    (reset),
		.uInstr   (uInstr),
		.incPc    (incPc),
		.busDone  (busDone),
		.readData (readData),
		.busReq   (busReq),
		.opcode   (opcode),
		.zFlag    (zFlag)
	);

	// Single Wishbone port for fetches and data
	wishboneMaster busMaster
	(
		.clock    (clock),
		.reset    (reset),
		.busReq   (busReq),
		.busDone  (busDone),
		.readData (readData),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.datOut   (datOut),
		.datIn    (datIn),
		.ack      (ack)
	);

endmodule

/* dv/microCoreChecker.sv */
`timescale 1ns/1ps

module microCoreChecker
(
	input logic        clock,
	input logic        reset,
	input logic        cyc,
	input logic        stb,
	input logic        we,
	input logic        ack,
	input logic [15:0] adr,
	input logic [7:0]  datOut,
	input logic        halted
);

	localparam int maxWrites = 8;

	logic [15:0] expAddr [0:maxWrites-1];
	logic [7:0]  expData [0:maxWrites-1];
	int          expCount;
	int          seen;
	int          testErrors;
	int          passCount;
	int          failCount;
	logic        firstSeen;
	string       curName;

	initial
	begin
		expCount   = 0;
		seen       = 0;
		testErrors = 0;
		passCount  = 0;
		failCount  = 0;
		firstSeen  = 1'b0;
		curName    = "none";
	end

	//////////////////////////////
	// Test bookkeeping
	//////////////////////////////

	task automatic reportError(input string msg);
		$display("FAIL %0t: %s: %s", $time, curName, msg);
		testErrors++;
	endtask

	task automatic beginTest(input string name);
		curName    = name;
		expCount   = 0;
		seen       = 0;
		testErrors = 0;
		firstSeen  = 1'b0;
	endtask

	task automatic expectWrite(input logic [15:0] addr, input logic [7:0] data);
		expAddr[expCount] = addr;
		expData[expCount] = data;
		expCount++;
	endtask

	// Bus quiet right after reset
	task automatic checkIdle();
		if (cyc || stb || we || halted)
			reportError("bus or halted not low after reset");
	endtask

	task automatic endTest(input logic expHalt, input logic timedOut);
		if (timedOut)
		begin
			$display("%s: core did not halt within the timeout", curName);
			testErrors++;
		end
		else if (halted !== expHalt)
			reportError($sformatf("halted is %b, expected %b", halted, expHalt));
		if (seen != expCount)
			reportError($sformatf("saw %0d writes, expected %0d", seen, expCount));
		if (testErrors == 0)
		begin
			passCount++;
			$display("test %s: passed, %0d writes", curName, seen);
		end
		else
		begin
			failCount++;
			$display("test %s: failed with %0d errors", curName, testErrors);
		end
	endtask

	task automatic reportTotals();
		$display("tests run %0d, passed %0d, failed %0d",
			passCount + failCount, passCount, failCount);
	endtask

	//////////////////////////////
	// Bus monitor
	//////////////////////////////

	// A beat completes on ack
	always @(posedge clock)
	begin
		if (!reset && cyc && stb && ack)
		begin
			// Very first access is the fetch at 0
			if (!firstSeen)
			begin
				firstSeen = 1'b1;
				if (we || adr != 16'h0000)
					reportError($sformatf("first access we=%b adr=%h", we, adr));
			end
			if (we)
			begin
				if (seen >= expCount)
					reportError($sformatf("extra write %h to %h", datOut, adr));
				else if (adr !== expAddr[seen] || datOut !== expData[seen])
					reportError($sformatf("write %0d got %h to %h, expected %h to %h",
						seen, datOut, adr, expData[seen], expAddr[seen]));
				seen++;
			end
		end
	end

endmodule

/* dv/microCoreTb.sv */
`timescale 1ns/1ps

module microCoreTb;

	localparam int maxTests      = 16;
	localparam int maxWrites     = 8;
	localparam int timeoutCycles = 4000;
	localparam int holdCycles    = 4;

	logic        clock;
	logic        reset;
	logic        ack;
	logic [7:0]  datIn;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [15:0] adr;
	logic [7:0]  datOut;
	logic        halted;

	// Memory model state
	logic [7:0]  mem [0:65535];
	logic [31:0] rngState;
	int          waitLeft;
	logic        busy;

	// Program table
	string        progName  [0:maxTests-1];
	logic [127:0] progCode  [0:maxTests-1];
	int           progLen   [0:maxTests-1];
	logic [15:0]  wrAddr    [0:maxTests-1][0:maxWrites-1];
	logic [7:0]   wrData    [0:maxTests-1][0:maxWrites-1];
	int           wrCount   [0:maxTests-1];
	logic         expHalt   [0:maxTests-1];
	int           numTests;

	microCore u_microCore
	(
		.clock  (clock),
		.reset  (reset),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.datOut (datOut),
		.datIn  (datIn),
		.ack    (ack),
		.halted (halted)
	);

	microCoreChecker u_checker
	(
		.clock  (clock),
		.reset  (reset),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.ack    (ack),
		.adr    (adr),
		.datOut (datOut),
		.halted (halted)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////
	// Wishbone slave memory
	//////////////////////////////

	// 0 to 3 wait cycles per beat and a one-cycle ack
	always @(posedge clock)
	begin
		#1;
		if (reset)
		begin
			ack  = 1'b0;
			busy = 1'b0;
		end
		else if (ack)
			ack = 1'b0;
		else if (cyc && stb)
		begin
			if (!busy)
			begin
				busy     = 1'b1;
				rngState = xorshift(rngState);
				waitLeft = rngState % 4;
			end
			if (waitLeft == 0)
			begin
				if (we)
					mem[adr] = datOut;
				else
					datIn = mem[adr];
				ack  = 1'b1;
				busy = 1'b0;
			end
			else
				waitLeft--;
		end
	end

	//////////////////////////////
	// Table building
	//////////////////////////////

	// Code is right aligned with the first byte most significant
	task automatic addProgram(input string name, input logic [127:0] code, input int len);
		progName[numTests] = name;
		progCode[numTests] = code;
		progLen[numTests]  = len;
		wrCount[numTests]  = 0;
		expHalt[numTests]  = 1'b1;
		numTests++;
	endtask

	task automatic addWrite(input logic [15:0] addr, input logic [7:0] data);
		int t;
		t = numTests - 1;
		wrAddr[t][wrCount[t]] = addr;
		wrData[t][wrCount[t]] = data;
		wrCount[t]++;
	endtask

	task automatic buildTable();
		logic [7:0] incVal;
		logic [7:0] decAVal;
		logic [7:0] decBVal;
		logic [7:0] loopCount;
		incVal    = 8'hFF;
		decAVal   = 8'h00;
		decBVal   = 8'h40;
		loopCount = 8'h03;
		numTests  = 0;
		// LD A,n / LD HL,nn / LD (HL),A / LD (HL+),A twice
		addProgram("ldStore", {8'h3E, 8'h5C, 8'h21, 8'h34, 8'h12, 8'h77, 8'h22, 8'h22,
			8'h76}, 9);
		addWrite(16'h1234, 8'h5C);
		addWrite(16'h1234, 8'h5C);
		addWrite(16'h1235, 8'h5C);
		// INC C wraps and PUSH BC stores it
		addProgram("incC", {8'h06, 8'h11, 8'h0E, incVal, 8'h0C, 8'hC5, 8'h76}, 7);
		addWrite(16'hFFFD, 8'h11);
		addWrite(16'hFFFC, incVal + 8'd1);
		addProgram("decA", {8'h3E, decAVal, 8'h21, 8'h00, 8'h90, 8'h3D, 8'h77, 8'h76}, 8);
		addWrite(16'h9000, decAVal - 8'd1);
		addProgram("decB", {8'h06, decBVal, 8'h0E, 8'h22, 8'h05, 8'hC5, 8'h76}, 7);
		addWrite(16'hFFFD, decBVal - 8'd1);
		addWrite(16'hFFFC, 8'h22);
		// Loop body at 7 and offset taken from 11
		addProgram("jrLoop", {8'h06, loopCount, 8'h21, 8'h00, 8'h80, 8'h3E, 8'h5A, 8'h22,
			8'h05, 8'h20, 8'hFC, 8'h76}, 12);
		for (int i = 0; i < loopCount; i++)
			addWrite(16'h8000 + 16'(i), 8'h5A);
		// JR skips the HALT at 7
		addProgram("jrAlways", {8'h3E, 8'h66, 8'h21, 8'h00, 8'h70, 8'h18, 8'h01, 8'h76,
			8'h77, 8'h76}, 10);
		addWrite(16'h7000, 8'h66);
		// Not taken stores to 9000 and taken sets L first
		addProgram("cpEqual", {8'h3E, 8'h42, 8'h21, 8'h00, 8'h90, 8'hFE, 8'h42, 8'h20,
			8'h02, 8'h77, 8'h76, 8'h2E, 8'h01, 8'h77, 8'h76}, 15);
		addWrite(16'h9000, 8'h42);
		addProgram("cpDiffer", {8'h3E, 8'h42, 8'h21, 8'h00, 8'h90, 8'hFE, 8'h41, 8'h20,
			8'h02, 8'h77, 8'h76, 8'h2E, 8'h01, 8'h77, 8'h76}, 15);
		addWrite(16'h9001, 8'h42);
		// Bit set clears Z so NZ branches
		addProgram("bitSet", {8'h3E, 8'h33, 8'h21, 8'h00, 8'hC0, 8'hCB, 8'h7C, 8'h20,
			8'h02, 8'h77, 8'h76, 8'h2E, 8'h01, 8'h77, 8'h76}, 15);
		addWrite(16'hC001, 8'h33);
		addProgram("bitClear", {8'h3E, 8'h33, 8'h21, 8'h00, 8'h40, 8'hCB, 8'h7C, 8'h20,
			8'h02, 8'h77, 8'h76, 8'h2E, 8'h01, 8'h77, 8'h76}, 15);
		addWrite(16'h4000, 8'h33);
		// CALL at 5 to 0x000A with return address 8
		addProgram("callRet", {8'h3E, 8'h77, 8'h21, 8'h00, 8'hA0, 8'hCD, 8'h0A, 8'h00,
			8'h77, 8'h76, 8'h2E, 8'h05, 8'hC9}, 13);
		addWrite(16'hFFFD, 8'h00);
		addWrite(16'hFFFC, 8'h05 + 8'd3);
		addWrite(16'hA005, 8'h77);
		addProgram("pushBC", {8'h31, 8'h00, 8'hD0, 8'h06, 8'h12, 8'h0E, 8'h34, 8'hC5,
			8'h76}, 9);
		addWrite(16'hCFFF, 8'h12);
		addWrite(16'hCFFE, 8'h34);
		// Unknown opcodes act as NOP
		addProgram("nopSkip", {8'h00, 8'hD3, 8'h3E, 8'h99, 8'h21, 8'h10, 8'h20, 8'h77,
			8'h76}, 9);
		addWrite(16'h2010, 8'h99);
	endtask

	//////////////////////////////
	// Per test
	//////////////////////////////

	task automatic loadProgram(input int t);
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'h00;
		for (int i = 0; i < progLen[t]; i++)
			mem[i] = progCode[t][8*(progLen[t]-1-i) +: 8];
	endtask

	task automatic runTest(input int t);
		int   cycles;
		logic timedOut;
		@(posedge clock);
		#1 reset = 1'b1;
		@(posedge clock);
		// Memory model is idle under reset
		#2;
		loadProgram(t);
		u_checker.beginTest(progName[t]);
		for (int i = 0; i < wrCount[t]; i++)
			u_checker.expectWrite(wrAddr[t][i], wrData[t][i]);
		@(posedge clock);
		#1 reset = 1'b0;
		u_checker.checkIdle();
		cycles = 0;
		while (!halted && cycles < timeoutCycles)
		begin
			@(posedge clock);
			#1;
			cycles++;
		end
		timedOut = !halted;
		// Halted must stay high and the bus stay quiet
		for (int i = 0; i < holdCycles; i++)
			@(posedge clock);
		#1;
		u_checker.endTest(expHalt[t], timedOut);
	endtask

	initial
	begin
		reset    = 1'b1;
		ack      = 1'b0;
		datIn    = 8'h00;
		busy     = 1'b0;
		waitLeft = 0;
		rngState = 32'ha779;
		buildTable();
		for (int t = 0; t < numTests; t++)
			runTest(t);
		u_checker.reportTotals();
		if (u_checker.failCount == 0 && u_checker.passCount == numTests)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* microCore.f */
rtl/ucodePkg.sv
rtl/opcodeDecoder.sv
rtl/microcodeRom.sv
rtl/microSequencer.sv
rtl/coreDatapath.sv
rtl/wishboneMaster.sv
rtl/microCore.sv
dv/microCoreChecker.sv
dv/microCoreTb.sv

/* Makefile */
# Verilator build and run for the microcoded core

VERILATOR ?= verilator
TOP       ?= microCoreTb
LINT_TOP  ?= microCoreTb
FILELIST  ?= microCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
SOURCES   := $(wildcard rtl/*.sv) $(wildcard dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
